//--- src/timer_pkg.sv
// ----------------------------------------------------------------------
// shared types and address map of the APB timer subsystem
// all registers are 32-bit words and byte lanes are not supported
// register offsets are decoded on paddr[5:2] only
// ----------------------------------------------------------------------
package timer_pkg;

	// ------------------------------------------------------------------
	// widths with a meaning
	// ------------------------------------------------------------------

	// APB byte address, 16-bit peripheral space
	typedef logic [15:0] apb_addr_t;
	// APB data word
	typedef logic [31:0] apb_data_t;
	// timer count and compare value
	typedef logic [63:0] mtime_t;

	// ------------------------------------------------------------------
	// APB bus
	// ------------------------------------------------------------------

	// master to slave
	typedef struct packed {
		logic      psel;
		logic      penable;
		logic      pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
	} apb_req_t;

	// slave to master
	typedef struct packed {
		apb_data_t prdata;
		logic      pready;
		logic      pslverr;
	} apb_rsp_t;

	// ------------------------------------------------------------------
	// address map
	// ------------------------------------------------------------------

	// timer window in the top two address bits
	localparam apb_addr_t TIMER_WIN_BASE = 16'h0000;
	localparam apb_addr_t WIN_MASK       = 16'hc000;

	// timer register byte offsets
	localparam apb_addr_t REG_CTRL      = 16'h0000;
	localparam apb_addr_t REG_MTIME     = 16'h0008;
	localparam apb_addr_t REG_MTIMEH    = 16'h000c;
	localparam apb_addr_t REG_MTIMECMP  = 16'h0010;
	localparam apb_addr_t REG_MTIMECMPH = 16'h0014;

endpackage

//--- src/us_tick_gen.sv
// ----------------------------------------------------------------------
// microsecond timebase, one-cycle tick every CLK_MHZ clock cycles
// CLK_MHZ must be a whole number of MHz, 1 or more
// first tick arrives CLK_MHZ cycles after reset is released
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module us_tick_gen #(
	parameter int CLK_MHZ = 27
) (
	input  logic clk,
	input  logic rst_n,
	output logic tick
);

	// counter must hold CLK_MHZ - 1, and at least one bit
	localparam int CW = (CLK_MHZ > 1) ? $clog2(CLK_MHZ) : 1;
	localparam logic [CW-1:0] RELOAD = CW'(CLK_MHZ - 1);

	logic [CW-1:0] tick_ctr;
	logic          ctr_zero;

	assign ctr_zero = (tick_ctr == '0);

	// down-counter, reloads after reaching zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_ctr <= RELOAD;
		end else if (ctr_zero) begin
			tick_ctr <= RELOAD;
		end else begin
			tick_ctr <= tick_ctr - 1'b1;
		end
	end

	// registered strobe marks each reload
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick <= 1'b0;
		end else begin
			tick <= ctr_zero;
		end
	end

endmodule

//--- src/apb_window_decode.sv
// ----------------------------------------------------------------------
// APB window decoder with a single slave and an error path
// purely combinational, adds no wait states
// accesses outside the timer window complete at once with pslverr
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module apb_window_decode (
	input  timer_pkg::apb_req_t bus_req,
	output timer_pkg::apb_rsp_t bus_rsp,
	output timer_pkg::apb_req_t timer_req,
	input  timer_pkg::apb_rsp_t timer_rsp
);

	import timer_pkg::*;

	logic timer_hit;
	logic access_phase;

	// ------------------------------------------------------------------
	// window match
	// ------------------------------------------------------------------

	assign timer_hit    = ((bus_req.paddr & WIN_MASK) == TIMER_WIN_BASE);
	assign access_phase = bus_req.psel & bus_req.penable;

	// ------------------------------------------------------------------
	// request path
	// ------------------------------------------------------------------

	// everything passes through, select only inside the window
	always_comb begin
		timer_req      = bus_req;
		timer_req.psel = bus_req.psel & timer_hit;
	end

	// ------------------------------------------------------------------
	// response path
	// ------------------------------------------------------------------

	always_comb begin
		if (timer_hit) begin
			bus_rsp = timer_rsp;
		end else begin
			// unmapped window
			bus_rsp.prdata  = '0;
			bus_rsp.pready  = 1'b1;
			bus_rsp.pslverr = access_phase;
		end
	end

endmodule

//--- src/mtimer.sv
// ----------------------------------------------------------------------
// RISC-V style machine timer on APB, 64-bit mtime and mtimecmp
// mtime counts on tick while enabled and freezes during debug halt
// irq is a level, high while mtime >= mtimecmp, one cycle late
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module mtimer (
	input  logic                clk,
	input  logic                rst_n,
	input  timer_pkg::apb_req_t req,
	output timer_pkg::apb_rsp_t rsp,
	input  logic                tick,
	input  logic                dbg_halt,
	output logic                irq
);

	import timer_pkg::*;

	// word offsets as seen on paddr[5:2]
	localparam logic [3:0] OFS_CTRL      = REG_CTRL[5:2];
	localparam logic [3:0] OFS_MTIME     = REG_MTIME[5:2];
	localparam logic [3:0] OFS_MTIMEH    = REG_MTIMEH[5:2];
	localparam logic [3:0] OFS_MTIMECMP  = REG_MTIMECMP[5:2];
	localparam logic [3:0] OFS_MTIMECMPH = REG_MTIMECMPH[5:2];

	logic       bus_wr;
	logic [3:0] ofs;

	logic wr_ctrl;
	logic wr_mtime_lo;
	logic wr_mtime_hi;
	logic wr_cmp_lo;
	logic wr_cmp_hi;

	logic      ctrl_en;
	mtime_t    mtime;
	mtime_t    mtimecmp;
	logic      count_en;
	apb_data_t rd_data;

	// ------------------------------------------------------------------
	// register write strobes
	// ------------------------------------------------------------------

	// no wait states, so the access phase is the last one
	assign bus_wr = req.psel & req.penable & req.pwrite;
	assign ofs    = req.paddr[5:2];

	assign wr_ctrl     = bus_wr && (ofs == OFS_CTRL);
	assign wr_mtime_lo = bus_wr && (ofs == OFS_MTIME);
	assign wr_mtime_hi = bus_wr && (ofs == OFS_MTIMEH);
	assign wr_cmp_lo   = bus_wr && (ofs == OFS_MTIMECMP);
	assign wr_cmp_hi   = bus_wr && (ofs == OFS_MTIMECMPH);

	// ------------------------------------------------------------------
	// control
	// ------------------------------------------------------------------

	// bit 0 enables counting
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_en <= 1'b0;
		end else if (wr_ctrl) begin
			ctrl_en <= req.pwdata[0];
		end
	end

	// ------------------------------------------------------------------
	// mtime
	// ------------------------------------------------------------------

	assign count_en = tick & ctrl_en & ~dbg_halt;

	// a software write to either half wins over the increment
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtime <= '0;
		end else if (wr_mtime_lo) begin
			mtime[31:0] <= req.pwdata;
		end else if (wr_mtime_hi) begin
			mtime[63:32] <= req.pwdata;
		end else if (count_en) begin
			mtime <= mtime + 64'd1;
		end
	end

	// ------------------------------------------------------------------
	// mtimecmp
	// ------------------------------------------------------------------

	// all ones out of reset keeps irq quiet
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtimecmp <= '1;
		end else begin
			if (wr_cmp_lo) begin
				mtimecmp[31:0] <= req.pwdata;
			end
			if (wr_cmp_hi) begin
				mtimecmp[63:32] <= req.pwdata;
			end
		end
	end

	// ------------------------------------------------------------------
	// interrupt
	// ------------------------------------------------------------------

	// compares the registered values, so irq follows one cycle late
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			irq <= 1'b0;
		end else begin
			irq <= (mtime >= mtimecmp);
		end
	end

	// ------------------------------------------------------------------
	// read data
	// ------------------------------------------------------------------

	always_comb begin
		case (ofs)
			OFS_CTRL: begin
				rd_data = {31'd0, ctrl_en};
			end
			OFS_MTIME: begin
				rd_data = mtime[31:0];
			end
			OFS_MTIMEH: begin
				rd_data = mtime[63:32];
			end
			OFS_MTIMECMP: begin
				rd_data = mtimecmp[31:0];
			end
			OFS_MTIMECMPH: begin
				rd_data = mtimecmp[63:32];
			end
			default: begin
				// unknown offsets read as zero, no error
				rd_data = '0;
			end
		endcase
	end

	// never stretches a transfer, never errors
	assign rsp = '{prdata: rd_data, pready: 1'b1, pslverr: 1'b0};

endmodule

//--- src/timer_subsys.sv
// ----------------------------------------------------------------------
// APB timer subsystem, tick generator, window decoder and mtimer
// CLK_MHZ sets the clock frequency in MHz for the microsecond tick
// every APB transfer takes exactly two cycles, mapped or not
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module timer_subsys #(
	parameter int CLK_MHZ = 27
) (
	input  logic                clk,
	input  logic                rst_n,
	input  timer_pkg::apb_req_t bus_req,
	output timer_pkg::apb_rsp_t bus_rsp,
	input  logic                dbg_halt,
	output logic                timer_irq
);

	import timer_pkg::*;

	apb_req_t timer_req;
	apb_rsp_t timer_rsp;
	logic     tick;

	// ------------------------------------------------------------------
	// microsecond timebase
	// ------------------------------------------------------------------

	us_tick_gen #(
		.CLK_MHZ (CLK_MHZ)
	) u_tick_gen (
		.clk   (clk),
		.rst_n (rst_n),
		.tick  (tick)
	);

	// ------------------------------------------------------------------
	// bus decode
	// ------------------------------------------------------------------

	apb_window_decode u_decode (
		.bus_req   (bus_req),
		.bus_rsp   (bus_rsp),
		.timer_req (timer_req),
		.timer_rsp (timer_rsp)
	);

	// ------------------------------------------------------------------
	// machine timer
	// ------------------------------------------------------------------

	mtimer u_mtimer (
		.clk      (clk),
		.rst_n    (rst_n),
		.req      (timer_req),
		.rsp      (timer_rsp),
		.tick     (tick),
		.dbg_halt (dbg_halt),
		.irq      (timer_irq)
	);

endmodule

//--- tb/timer_subsys_props.sv
// ----------------------------------------------------------------------
// APB response and interrupt properties, bound into timer_subsys
// checked only while rst_n is high
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module timer_subsys_props (
	input logic                clk,
	input logic                rst_n,
	input timer_pkg::apb_req_t bus_req,
	input timer_pkg::apb_rsp_t bus_rsp,
	input logic                timer_irq
);

	import timer_pkg::*;

	int   pready_fails = 0;
	int   window_fails = 0;
	int   irq_fails = 0;
	int   fail_cnt;
	logic access_cycle;
	logic in_window;

	assign access_cycle = bus_req.psel && bus_req.penable;
	assign in_window    = ((bus_req.paddr & WIN_MASK) == TIMER_WIN_BASE);
	assign fail_cnt     = pready_fails + window_fails + irq_fails;

	// no wait states anywhere
	a_pready: assert property (@(posedge clk) disable iff (!rst_n)
		access_cycle |-> bus_rsp.pready)
	else begin
		$error("pready low in an access cycle");
		pready_fails++;
	end

	// the timer window never errors
	a_window_ok: assert property (@(posedge clk) disable iff (!rst_n)
		(access_cycle && in_window) |-> !bus_rsp.pslverr)
	else begin
		$error("pslverr inside the timer window");
		window_fails++;
	end

	a_irq_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(timer_irq))
	else begin
		$error("timer_irq is unknown");
		irq_fails++;
	end

endmodule

bind timer_subsys timer_subsys_props u_props (
	.clk       (clk),
	.rst_n     (rst_n),
	.bus_req   (bus_req),
	.bus_rsp   (bus_rsp),
	.timer_irq (timer_irq)
);

//--- tb/timer_subsys_tb.sv
// ----------------------------------------------------------------------
// testbench for the APB timer subsystem, acts as the APB master
// runs the access cases of tb/timer_cases.txt from the project root
// CLK_MHZ is 4, so mtime advances once every 4 clock cycles
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module timer_subsys_tb;

	import timer_pkg::*;

	localparam int CLK_MHZ  = 4;
	localparam int NAME_W   = 8 * 20;
	localparam int FIELD_W  = 8 * 12;
	localparam int LINE_W   = 8 * 128;
	localparam int SLACK    = 200;
	localparam     CASE_FILE = "tb/timer_cases.txt";

	logic     clk;
	logic     rst_n;
	apb_req_t bus_req;
	apb_rsp_t bus_rsp;
	logic     dbg_halt;
	logic     timer_irq;

	int        err_cnt;
	int        check_cnt;
	int        cycle_cnt = 0;
	int        cycle_limit = 0;
	int        fd;
	apb_data_t last_rdata;

	timer_subsys #(
		.CLK_MHZ (CLK_MHZ)
	) UUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.bus_req   (bus_req),
		.bus_rsp   (bus_rsp),
		.dbg_halt  (dbg_halt),
		.timer_irq (timer_irq)
	);

	// ------------------------------------------------------------------
	// clock and cycle watchdog
	// ------------------------------------------------------------------

	initial clk = 1'b0;
	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	initial begin : watchdog
		wait (cycle_limit > 0);
		while (cycle_cnt < cycle_limit) begin
			@(posedge clk);
		end
		$display("timeout, the case file did not finish within %0d cycles", cycle_limit);
		$display("checks %0d, mismatches %0d", check_cnt, err_cnt);
		$display("test failed");
		$finish;
	end

	// ------------------------------------------------------------------
	// APB master
	// ------------------------------------------------------------------

	// setup cycle, then access cycles until pready, sampled at the negedge
	task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
			output apb_data_t rdata, output logic slverr, output logic irq_seen);
		bus_req.psel    = 1'b1;
		bus_req.penable = 1'b0;
		bus_req.pwrite  = wr;
		bus_req.paddr   = addr;
		bus_req.pwdata  = wr ? wdata : '0;
		@(posedge clk);
		#1;
		bus_req.penable = 1'b1;
		@(negedge clk);
		while (!bus_rsp.pready) begin
			@(posedge clk);
			@(negedge clk);
		end
		rdata    = bus_rsp.prdata;
		slverr   = bus_rsp.pslverr;
		irq_seen = timer_irq;
		@(posedge clk);
		#1;
		bus_req = '0;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic check_field(input logic [NAME_W-1:0] name, input string what,
			input logic [31:0] expected, input logic [31:0] actual);
		check_cnt++;
		if (actual !== expected) begin
			err_cnt++;
			$display("[FAIL] %0s %0s expected %h actual %h", name, what, expected, actual);
		end
	endtask

	// ------------------------------------------------------------------
	// case file
	// ------------------------------------------------------------------

	// wait cycles plus 4 cycles per access, plus slack
	function automatic int case_cycle_limit(input int f);
		logic [LINE_W-1:0]  line;
		logic [NAME_W-1:0]  name;
		logic [7:0]         op;
		logic [FIELD_W-1:0] addr_s;
		logic [FIELD_W-1:0] data_s;
		logic [FIELD_W-1:0] rexp_s;
		logic [FIELD_W-1:0] err_s;
		logic [FIELD_W-1:0] irq_s;
		int                 fields;
		int                 n;
		int                 total;
		total = SLACK;
		while ($fgets(line, f) != 0) begin
			fields = $sscanf(line, "%s %s %s %s %s %s %s",
				name, op, addr_s, data_s, rexp_s, err_s, irq_s);
			if (fields == 7 && name != "#") begin
				n = 0;
				fields = $sscanf(data_s, "%h", n);
				if (op == "D" || op == "B") begin
					total += n;
				end
				if (op == "W" || op == "R" || op == "B") begin
					total += 4;
				end
			end
		end
		return total;
	endfunction

	task automatic run_case(input logic [NAME_W-1:0] name, input logic [7:0] op,
			input logic [FIELD_W-1:0] addr_s, input logic [FIELD_W-1:0] data_s,
			input logic [FIELD_W-1:0] rexp_s, input logic [FIELD_W-1:0] err_s,
			input logic [FIELD_W-1:0] irq_s);
		apb_addr_t addr;
		apb_data_t data;
		apb_data_t rexp;
		apb_data_t rdata;
		apb_data_t lo;
		apb_data_t hi;
		logic      exp_err;
		logic      exp_irq;
		logic      slverr;
		logic      irq_seen;
		int        n;
		addr    = '0;
		data    = '0;
		rexp    = '0;
		exp_err = 1'b0;
		exp_irq = 1'b0;
		n = $sscanf(addr_s, "%h", addr);
		n = $sscanf(data_s, "%h", data);
		n = $sscanf(err_s, "%h", exp_err);
		if (rexp_s != "x" && rexp_s != "s") begin
			n = $sscanf(rexp_s, "%h", rexp);
		end
		if (irq_s != "x") begin
			n = $sscanf(irq_s, "%h", exp_irq);
		end
		if (op == "H") begin
			dbg_halt = data[0];
		end else if (op == "D") begin
			wait_cycles(data);
		end else if (op == "W" || op == "R" || op == "B") begin
			if (op == "B") begin
				wait_cycles(data);
			end
			apb_access(op == "W", addr, data, rdata, slverr, irq_seen);
			if (op == "B") begin
				// one tick every CLK_MHZ cycles, access overhead gives the margin
				lo = rexp + data / CLK_MHZ - 1;
				hi = rexp + data / CLK_MHZ + 2;
				check_cnt++;
				if (rdata < lo || rdata > hi) begin
					err_cnt++;
					$display("[FAIL] %0s prdata expected %0d to %0d actual %0d",
						name, lo, hi, rdata);
				end
			end else if (rexp_s == "s") begin
				check_field(name, "prdata", last_rdata, rdata);
			end else if (rexp_s != "x") begin
				check_field(name, "prdata", rexp, rdata);
			end
			check_field(name, "pslverr", 32'(exp_err), 32'(slverr));
			if (irq_s != "x") begin
				check_field(name, "timer_irq", 32'(exp_irq), 32'(irq_seen));
			end
			if (op != "W") begin
				last_rdata = rdata;
			end
		end else begin
			err_cnt++;
			$display("case %0s has an operation the testbench does not know", name);
		end
	endtask

	task automatic run_all_cases(input int f);
		logic [LINE_W-1:0]  line;
		logic [NAME_W-1:0]  name;
		logic [7:0]         op;
		logic [FIELD_W-1:0] addr_s;
		logic [FIELD_W-1:0] data_s;
		logic [FIELD_W-1:0] rexp_s;
		logic [FIELD_W-1:0] err_s;
		logic [FIELD_W-1:0] irq_s;
		int                 fields;
		while ($fgets(line, f) != 0) begin
			fields = $sscanf(line, "%s %s %s %s %s %s %s",
				name, op, addr_s, data_s, rexp_s, err_s, irq_s);
			if (fields == 7 && name != "#") begin
				run_case(name, op, addr_s, data_s, rexp_s, err_s, irq_s);
			end
		end
	endtask

	task automatic report_and_finish();
		int total;
		total = err_cnt + UUT.u_props.fail_cnt;
		$display("checks %0d, mismatches %0d, assertion failures %0d",
			check_cnt, err_cnt, UUT.u_props.fail_cnt);
		if (total == 0 && check_cnt > 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	endtask

	// ------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------

	initial begin
		bus_req    = '0;
		dbg_halt   = 1'b0;
		rst_n      = 1'b0;
		err_cnt    = 0;
		check_cnt  = 0;
		last_rdata = '0;
		fd = $fopen(CASE_FILE, "r");
		if (fd == 0) begin
			$display("cannot open the case file %0s", CASE_FILE);
			$display("test failed");
			$finish;
		end else begin
			cycle_limit = case_cycle_limit(fd);
			$fclose(fd);
			repeat (8) @(posedge clk);
			#1;
			rst_n = 1'b1;
			fd = $fopen(CASE_FILE, "r");
			run_all_cases(fd);
			$fclose(fd);
			wait_cycles(2);
			report_and_finish();
		end
	end

endmodule

//--- tb/timer_cases.txt
# name op addr data exp_rdata exp_err exp_irq
# numbers in hex, ops W R H D B, x is don't care, s is same as the last read
# B waits data cycles then reads, exp_rdata is the count it started from
reset_ctrl     R 0000 0        00000000 0 0
reset_mtime    R 0008 0        00000000 0 0
reset_mtimeh   R 000c 0        00000000 0 0
reset_cmp      R 0010 0        ffffffff 0 0
reset_cmph     R 0014 0        ffffffff 0 0
halt_on        H 0000 1        x        0 x
wr_ctrl        W 0000 1        x        0 x
rd_ctrl        R 0000 0        00000001 0 x
wr_mtime       W 0008 12345678 x        0 x
rd_mtime       R 0008 0        12345678 0 x
wr_mtimeh      W 000c 9abcdef0 x        0 x
rd_mtimeh      R 000c 0        9abcdef0 0 x
wr_cmp         W 0010 a5a5a5a5 x        0 x
rd_cmp         R 0010 0        a5a5a5a5 0 x
wr_cmph        W 0014 0f0f0f0f x        0 x
rd_cmph        R 0014 0        0f0f0f0f 0 x
rd_unknown     R 0018 0        00000000 0 x
wr_unmapped    W 4010 11111111 x        1 x
rd_win1        R 4000 0        00000000 1 x
rd_win2        R 8000 0        00000000 1 x
rd_win3        R c000 0        00000000 1 x
cmp_kept       R 0010 0        a5a5a5a5 0 x
clr_mtime      W 0008 0        x        0 x
clr_mtimeh     W 000c 0        x        0 x
enable         W 0000 1        x        0 x
halt_off       H 0000 0        x        0 x
count          B 0008 28       00000000 0 x
halt_freeze    H 0000 1        x        0 x
frozen_a       R 0008 0        x        0 x
frozen_wait    D 0000 14       x        0 x
frozen_b       R 0008 0        s        0 x
irq_cmph       W 0014 0        x        0 x
irq_mtime      W 0008 64       x        0 x
irq_cmp_above  W 0010 65       x        0 x
irq_low        R 0010 0        00000065 0 0
irq_cmp_equal  W 0010 64       x        0 x
irq_high       R 0010 0        00000064 0 1
irq_cmph_up    W 0014 1        x        0 x
irq_low_again  R 0014 0        00000001 0 0

//--- flist.f
src/timer_pkg.sv
src/us_tick_gen.sv
src/apb_window_decode.sv
src/mtimer.sv
src/timer_subsys.sv
tb/timer_subsys_props.sv
tb/timer_subsys_tb.sv
